//--- compile.f
prom_pkg.sv
prom_wb_regs.sv
prom_block_buffer.sv
prom_spi_engine.sv
prom_programmer.sv
spi_flash_model.sv
prom_assert.sv
tb_prom_programmer.sv

//--- tb_prom_programmer.sv
`timescale 1ns/10ps
`default_nettype none

module tb_prom_programmer;

    localparam int ack_limit   = 6000;   // Cycles, covers a full block drain
    localparam int poll_limit  = 3000;
    localparam int cmd_cycles  = 400;    // Worst case per single command with polling
    localparam int blk_cycles  = 64 * 80 + 800;
    localparam int total_cyc   = 16 + 8 * cmd_cycles + 2 * blk_cycles + 6 * cmd_cycles;
    localparam real watchdog_ns = 1.5 * total_cyc * 40.0;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [6:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        prom_miso;
    logic        prom_mosi;
    logic        prom_sclk;
    logic        prom_cs;
    logic [15:0] lfsr;
    int          errors;

    prom_programmer uut (
        .clk       (clk),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .prom_miso (prom_miso),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .prom_mosi (prom_mosi),
        .prom_sclk (prom_sclk),
        .prom_cs   (prom_cs)
    );

    spi_flash_model flash (
        .prom_cs   (prom_cs),
        .prom_sclk (prom_sclk),
        .prom_mosi (prom_mosi),
        .prom_miso (prom_miso)
    );

    always #20 clk = ~clk;

    // Model's memory contents, xor of the address bytes
    function automatic logic [7:0] byte_at(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'hA5;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // Galois step
        end
        return v;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            errors++;
            $display("error %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // Called 2 ns after a rising edge, returns 2 ns after the ack edge
    task automatic wb_cycle(input logic we, input logic [6:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        int n;
        n        = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!wb_ack && n < ack_limit);
        assert (wb_ack)
        else begin
            errors++;
            $display("no Wishbone acknowledge at address %0d", adr);
        end
        rdata = wb_dat_r;
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [6:0] adr, input logic [31:0] data);
        logic [31:0] dummy;
        wb_cycle(1'b1, adr, data, dummy);
    endtask

    task automatic wb_read(input logic [6:0] adr, output logic [31:0] data);
        wb_cycle(1'b0, adr, '0, data);
    endtask

    task automatic wb_read_check(input logic [6:0] adr, input logic [31:0] exp,
                                 input string name);
        logic [31:0] d;
        wb_read(adr, d);
        expect_eq(name, d, exp);
    endtask

    task automatic wait_idle();
        prom_pkg::prom_status_t st;
        int n;
        n = 0;
        do begin
            wb_read(prom_pkg::reg_cmd_status, st);
            n++;
        end while (st.busy && n < poll_limit);
        assert (!st.busy)
        else begin
            errors++;
            $display("engine stayed busy after %0d status polls", n);
        end
    endtask

    task automatic run_cmd(input logic [7:0] op, input logic [23:0] arg);
        wb_write(prom_pkg::reg_cmd_status, {op, arg});
        wait_idle();
        expect_eq("prom_cs", prom_cs, 1'b1);   // Deselected between commands
    endtask

    task automatic check_frame(input logic [7:0] exp[$], input bit exact);
        if (exact) begin
            expect_eq("rx_count", flash.rx_q.size(), exp.size());
        end else begin
            assert (flash.rx_q.size() >= exp.size())
            else begin
                errors++;
                $display("flash received %0d bytes, fewer than the %0d expected",
                         flash.rx_q.size(), exp.size());
            end
        end
        for (int i = 0; i < exp.size() && i < flash.rx_q.size(); i++)
            expect_eq($sformatf("rx_byte[%0d]", i), flash.rx_q[i], exp[i]);
    endtask

    task automatic read_ids();
        run_cmd(prom_pkg::op_rdid, 24'h0);
        wb_read_check(prom_pkg::reg_result, 32'h0020_2015, "result_rdid");
        run_cmd(prom_pkg::op_rdsr, 24'h0);
        wb_read_check(prom_pkg::reg_result, 32'h0000_001C, "result_rdsr");
        run_cmd(prom_pkg::op_res, 24'h0);
        wb_read_check(prom_pkg::reg_result, 32'h0000_0014, "result_res");
    endtask

    task automatic read_memory();
        logic [23:0] a;
        logic [31:0] exp;
        a   = 24'h01_2345;
        exp = {byte_at(a), byte_at(a + 1), byte_at(a + 2), byte_at(a + 3)};
        run_cmd(prom_pkg::op_read, a);
        check_frame('{8'h03, 8'h01, 8'h23, 8'h45}, 1'b0);
        wb_read_check(prom_pkg::reg_result, exp, "result_read");
        a   = 24'hFE_DC0B;
        exp = {byte_at(a), byte_at(a + 1), byte_at(a + 2), byte_at(a + 3)};
        run_cmd(prom_pkg::op_fast_read, a);
        check_frame('{8'h0B, 8'hFE, 8'hDC, 8'h0B, 8'h00}, 1'b0);  // Dummy byte last
        wb_read_check(prom_pkg::reg_result, exp, "result_fast_read");
    endtask

    task automatic send_write_cmds();
        run_cmd(prom_pkg::op_wren, 24'h0);
        check_frame('{8'h06}, 1'b1);
        run_cmd(prom_pkg::op_se, 24'h0A_0000);
        check_frame('{8'hD8, 8'h0A, 8'h00, 8'h00}, 1'b1);
        run_cmd(prom_pkg::op_wrsr, 24'h9C_0000);
        check_frame('{8'h01, 8'h9C}, 1'b1);
    endtask

    task automatic stream_block();
        logic [31:0] quads [$];
        logic [7:0]  exp [$];
        logic [31:0] v;
        int          len;
        len = take_bits(6) + 1;
        for (int i = 0; i < len; i++) begin
            v = take_bits(32);
            quads.push_back(v);
            exp.push_back(v[31:24]);
            exp.push_back(v[23:16]);
            exp.push_back(v[15:8]);
            exp.push_back(v[7:0]);
        end
        wb_write(prom_pkg::reg_blk_start, '0);
        for (int i = 0; i < len; i++)
            wb_write(prom_pkg::blk_window_base + i, quads[i]);
        wb_write(prom_pkg::reg_blk_end, '0);
        wait_idle();
        wb_read_check(prom_pkg::reg_result, len, "result_block");
        check_frame(exp, 1'b1);
    endtask

    task automatic block_with_gap();
        prom_pkg::prom_status_t st;
        wb_write(prom_pkg::reg_blk_start, '0);
        wb_write(prom_pkg::blk_window_base + 0, 32'h1111_0000);
        wb_write(prom_pkg::blk_window_base + 1, 32'h2222_0001);
        wb_write(prom_pkg::blk_window_base + 5, 32'hDEAD_0005);  // Out of order
        wb_write(prom_pkg::blk_window_base + 2, 32'h3333_0002);
        wb_write(prom_pkg::reg_blk_end, '0);
        wait_idle();
        wb_read_check(prom_pkg::reg_result, 32'd3, "result_block_err");
        wb_read(prom_pkg::reg_cmd_status, st);
        expect_eq("status_debug", st.debug, {8'd5, 8'd2});  // Address high, index low
        check_frame('{8'h11, 8'h11, 8'h00, 8'h00, 8'h22, 8'h22, 8'h00, 8'h01,
                      8'h33, 8'h33, 8'h00, 8'h02}, 1'b1);
        // Command behind a draining block
        wb_write(prom_pkg::reg_blk_start, '0);
        wb_write(prom_pkg::blk_window_base + 0, 32'hA5A5_0000);
        wb_write(prom_pkg::blk_window_base + 1, 32'h5A5A_0001);
        wb_write(prom_pkg::reg_blk_end, '0);
        wb_read(prom_pkg::reg_cmd_status, st);
        expect_eq("status_busy", st.busy, 1'b1);
        wb_write(prom_pkg::reg_cmd_status, {prom_pkg::op_wren, 24'h0});
        expect_eq("rx_count_at_ack", flash.rx_q.size(), 8);   // Block already out
        expect_eq("prom_cs_at_ack", prom_cs, 1'b1);
        wait_idle();
        check_frame('{8'h06}, 1'b1);
    endtask

    task automatic bitio_step(input logic [3:0] mask, input logic [3:0] val,
                              input logic cs_e, input logic sclk_e, input logic mosi_e);
        wb_write(prom_pkg::reg_cmd_status, {8'hFF, 16'h0, mask, val});
        wait_idle();
        expect_eq("prom_cs", prom_cs, cs_e);
        expect_eq("prom_sclk", prom_sclk, sclk_e);
        expect_eq("prom_mosi", prom_mosi, mosi_e);
    endtask

    task automatic drive_pins();
        bitio_step(4'b0001, 4'b0101, 1'b1, 1'b0, 1'b1);   // mosi, unmasked sclk and cs held
        bitio_step(4'b0100, 4'b0100, 1'b1, 1'b1, 1'b1);   // sclk
        bitio_step(4'b0100, 4'b0000, 1'b1, 1'b0, 1'b1);
        bitio_step(4'b1000, 4'b0000, 1'b0, 1'b0, 1'b1);   // cs
        bitio_step(4'b1000, 4'b1000, 1'b1, 1'b0, 1'b1);
        bitio_step(4'b0001, 4'b0000, 1'b1, 1'b0, 1'b0);
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clk      = 1'b0;
        reset    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        lfsr     = 16'd5982;
        errors   = 0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b1;
        expect_eq("prom_cs", prom_cs, 1'b1);
        expect_eq("prom_sclk", prom_sclk, 1'b0);
        expect_eq("prom_mosi", prom_mosi, 1'b0);
        wb_read_check(prom_pkg::reg_result, '0, "result_reset");
        read_ids();
        read_memory();
        send_write_cmds();
        stream_block();
        block_with_gap();
        drive_pins();
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- prom_assert.sv
`timescale 1ns/10ps
`default_nettype none

module prom_assert (
    input wire logic       clk,
    input wire logic       reset,
    input wire logic       wb_cyc,
    input wire logic       wb_stb,
    input wire logic       wb_ack,
    input wire logic       req_valid,
    input wire logic       prom_cs,
    input wire logic       prom_sclk,
    input wire logic [2:0] eng_state
);

    logic seen_req;   // Any request since reset

    always_ff @(posedge clk) begin
        if (!reset)
            seen_req <= 1'b0;
        else if (req_valid)
            seen_req <= 1'b1;
    end

    cs_high_until_req: assert property (@(posedge clk) disable iff (!reset)
        !seen_req |-> prom_cs)
        else $error("cs low before any request");

    sclk_low_when_idle_cs: assert property (@(posedge clk) disable iff (!reset)
        (prom_cs && eng_state != prom_pkg::st_idle) |-> !prom_sclk)
        else $error("sclk high with cs high during a transfer");

    ack_needs_stb: assert property (@(posedge clk) disable iff (!reset)
        wb_ack |-> $past(wb_stb && wb_cyc))
        else $error("wb_ack without a strobe");

endmodule

bind prom_programmer prom_assert u_assert (
    .clk       (clk),
    .reset     (reset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .req_valid (req_valid),
    .prom_cs   (prom_cs),
    .prom_sclk (prom_sclk),
    .eng_state (eng_state)
);

`default_nettype wire

//--- spi_flash_model.sv
`timescale 1ns/10ps
`default_nettype none

module spi_flash_model (
    input  wire logic prom_cs,
    input  wire logic prom_sclk,
    input  wire logic prom_mosi,
    output logic      prom_miso
);

    logic [7:0]  rx_q [$];      // Bytes of the current or last frame
    logic [7:0]  shreg;
    logic [31:0] resp;
    int          nbits;
    int          out_cnt;

    function automatic logic [7:0] mem_byte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'hA5;  // Depends on every address bit
    endfunction

    function automatic int hdr_len(input logic [7:0] op);
        case (op)
            8'h9F, 8'h05: return 8;
            8'h03, 8'hAB: return 32;
            8'h0B:        return 40;      // Opcode, address, dummy byte
            default:      return 0;       // No read phase
        endcase
    endfunction

    function automatic logic [31:0] response();
        logic [23:0] a;
        a = {rx_q[1], rx_q[2], rx_q[3]};
        case (rx_q[0])
            8'h9F:        return {8'h20, 8'h20, 8'h15, 8'h00};  // JEDEC ID
            8'h05:        return {8'h1C, 24'h0};                // Status register
            8'hAB:        return {8'h14, 24'h0};                // Electronic signature
            8'h03, 8'h0B: return {mem_byte(a), mem_byte(a + 1), mem_byte(a + 2),
                                  mem_byte(a + 3)};
            default:      return '0;
        endcase
    endfunction

    initial begin
        prom_miso = 1'b0;
        nbits     = 0;
        out_cnt   = 0;
    end

    always @(negedge prom_cs) begin
        rx_q.delete();                    // New frame
        nbits   = 0;
        out_cnt = 0;
    end

    always @(posedge prom_cs) prom_miso <= 1'b0;

    always @(posedge prom_sclk) begin
        if (!prom_cs) begin
            shreg = {shreg[6:0], prom_mosi};
            nbits++;
            if (nbits % 8 == 0)
                rx_q.push_back(shreg);
        end
    end

    // Data out on falling SCLK once the header is in
    always @(negedge prom_sclk) begin
        if (!prom_cs && rx_q.size() > 0 && hdr_len(rx_q[0]) != 0 &&
            nbits >= hdr_len(rx_q[0])) begin
            if (out_cnt == 0)
                resp = response();
            prom_miso <= resp[31];
            resp = resp << 1;
            out_cnt++;
        end
    end

endmodule

`default_nettype wire

//--- prom_programmer.sv
`timescale 1ns/10ps
`default_nettype none

module prom_programmer (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        wb_cyc,
    input  wire logic        wb_stb,
    input  wire logic        wb_we,
    input  wire logic [6:0]  wb_adr,
    input  wire logic [31:0] wb_dat_w,
    input  wire logic        prom_miso,
    output logic [31:0]      wb_dat_r,
    output logic             wb_ack,
    output logic             prom_mosi,
    output logic             prom_sclk,
    output logic             prom_cs
);

    prom_pkg::spi_req_t req;
    prom_pkg::blk_wr_t  blk_wr;
    logic               req_valid;
    logic               req_ready;
    logic               blk_start;
    logic               blk_end;
    logic               blk_open;
    logic [6:0]         rd_index;
    logic [6:0]         fill;
    logic [31:0]        rd_data;
    logic [31:0]        result;
    logic [2:0]         eng_state;
    logic [15:0]        debug;

    prom_wb_regs u_regs (           // Host side, produces requests and quadlets
        .clk       (clk),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .req_ready (req_ready),
        .result    (result),
        .eng_state (eng_state),
        .prom_cs   (prom_cs),
        .prom_sclk (prom_sclk),
        .prom_mosi (prom_mosi),
        .prom_miso (prom_miso),
        .blk_open  (blk_open),
        .debug     (debug),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .req       (req),
        .req_valid (req_valid),
        .blk_wr    (blk_wr),
        .blk_start (blk_start),
        .blk_end   (blk_end)
    );

    prom_block_buffer u_buffer (
        .clk       (clk),
        .reset     (reset),
        .blk_wr    (blk_wr),
        .blk_start (blk_start),
        .blk_end   (blk_end),
        .rd_index  (rd_index),
        .rd_data   (rd_data),
        .fill      (fill),
        .blk_open  (blk_open),
        .debug     (debug)
    );

    prom_spi_engine u_engine (      // Flash side
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_valid (req_valid),
        .rd_data   (rd_data),
        .fill      (fill),
        .blk_open  (blk_open),
        .prom_miso (prom_miso),
        .req_ready (req_ready),
        .rd_index  (rd_index),
        .result    (result),
        .eng_state (eng_state),
        .prom_mosi (prom_mosi),
        .prom_sclk (prom_sclk),
        .prom_cs   (prom_cs)
    );

endmodule

`default_nettype wire

//--- prom_spi_engine.sv
`timescale 1ns/10ps
`default_nettype none

module prom_spi_engine (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire prom_pkg::spi_req_t req,
    input  wire logic               req_valid,
    input  wire logic [31:0]        rd_data,
    input  wire logic [6:0]         fill,
    input  wire logic               blk_open,
    input  wire logic               prom_miso,
    output logic                    req_ready,
    output logic [6:0]              rd_index,
    output logic [31:0]             result,
    output logic [2:0]              eng_state,
    output logic                    prom_mosi,
    output logic                    prom_sclk,
    output logic                    prom_cs
);

    logic [2:0]  state;
    logic [6:0]  seqn;         // Sequence counter, bit 0 is SCLK
    logic [6:0]  send_last;    // 2*send-1
    logic [6:0]  recv_last;    // 2*recv-1
    logic        recv_on;      // Command has a read phase
    logic [1:0]  kind_q;
    logic [31:0] data;         // Outgoing shift register, MSB on the pin
    logic        blk_shift;    // Quadlet in flight

    assign req_ready = (state == prom_pkg::st_idle);
    assign eng_state = state;
    assign prom_sclk = seqn[0];
    assign prom_mosi = data[31];

    always_ff @(posedge clk) begin
        if (!reset) begin
            state     <= prom_pkg::st_idle;
            seqn      <= '0;
            send_last <= '0;
            recv_last <= '0;
            recv_on   <= 1'b0;
            kind_q    <= prom_pkg::kind_cmd;
            data      <= '0;
            blk_shift <= 1'b0;
            rd_index  <= '0;
            result    <= '0;
            prom_cs   <= 1'b1;
        end else begin
            case (state)
                prom_pkg::st_idle: begin
                    if (req_valid && req.kind == prom_pkg::kind_bitio) begin
                        // Masked pins only, held until the next request
                        if (req.cmd.bitio.mask_mosi)
                            data[31] <= req.cmd.bitio.val_mosi;
                        if (req.cmd.bitio.mask_sclk)
                            seqn[0] <= req.cmd.bitio.val_sclk;
                        if (req.cmd.bitio.mask_cs)
                            prom_cs <= req.cmd.bitio.val_cs;
                    end else if (req_valid) begin
                        kind_q    <= req.kind;
                        data      <= req.cmd;
                        seqn      <= '0;
                        send_last <= (req.send_bits << 1) - 7'd1;
                        recv_last <= (req.recv_bits << 1) - 7'd1;
                        recv_on   <= (req.recv_bits != '0);
                        rd_index  <= '0;
                        state     <= prom_pkg::st_select;
                    end
                end

                prom_pkg::st_select: begin
                    prom_cs   <= 1'b0;
                    result    <= '0;
                    blk_shift <= 1'b0;
                    state     <= (kind_q == prom_pkg::kind_block) ?
                                 prom_pkg::st_write_block : prom_pkg::st_write;
                end

                prom_pkg::st_write: begin
                    if (seqn[0])
                        data <= data << 1;          // MOSI moves on falling SCLK
                    if (seqn == send_last) begin
                        seqn  <= '0;
                        state <= recv_on ? prom_pkg::st_read : prom_pkg::st_deselect;
                    end else begin
                        seqn <= seqn + 7'd1;
                    end
                end

                prom_pkg::st_write_block: begin
                    if (blk_shift) begin
                        if (seqn[0])
                            data <= data << 1;
                        if (seqn == send_last) begin
                            seqn      <= '0;
                            blk_shift <= 1'b0;     // Quadlet out
                        end else begin
                            seqn <= seqn + 7'd1;
                        end
                    end else if (fill > rd_index) begin
                        data      <= rd_data;      // Next quadlet ready
                        rd_index  <= rd_index + 7'd1;
                        blk_shift <= 1'b1;
                    end else if (!blk_open) begin
                        result <= {25'd0, rd_index};  // Quadlets written
                        state  <= prom_pkg::st_deselect;
                    end
                end

                prom_pkg::st_read: begin
                    if (!seqn[0])
                        result <= {result[30:0], prom_miso};  // Sample on rising SCLK
                    if (seqn == recv_last) begin
                        seqn  <= '0;
                        state <= prom_pkg::st_deselect;
                    end else begin
                        seqn <= seqn + 7'd1;
                    end
                end

                prom_pkg::st_deselect: begin
                    prom_cs <= 1'b1;
                    data    <= '0;                  // MOSI back to quiet level
                    state   <= prom_pkg::st_settle;
                end

                prom_pkg::st_settle: state <= prom_pkg::st_idle;

                default: state <= prom_pkg::st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- prom_block_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module prom_block_buffer (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire prom_pkg::blk_wr_t  blk_wr,
    input  wire logic               blk_start,
    input  wire logic               blk_end,
    input  wire logic [6:0]         rd_index,
    output logic [31:0]             rd_data,
    output logic [6:0]              fill,
    output logic                    blk_open,
    output logic [15:0]             debug
);

    logic [31:0] mem [0:63];
    logic [6:0]  wr_index;     // Next expected quadlet, 64 means full
    logic        take;         // Write is in order and fits

    assign take    = blk_wr.wen && blk_open && !wr_index[6] &&
                     (blk_wr.addr == wr_index[5:0]);
    assign fill    = wr_index;
    assign rd_data = mem[rd_index[5:0]];   // Async read, valid as soon as fill moves

    always_ff @(posedge clk) begin
        if (take)
            mem[wr_index[5:0]] <= blk_wr.data;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_index <= '0;
            blk_open <= 1'b0;
            debug    <= '0;
        end else if (blk_start) begin
            wr_index <= '0;
            blk_open <= 1'b1;
            debug    <= '0;          // Clear last error
        end else if (blk_wr.wen && blk_open) begin
            if (take)
                wr_index <= wr_index + 7'd1;
            else
                debug <= {2'b00, blk_wr.addr, 1'b0, wr_index};  // Out of order, dropped
        end else if (blk_end) begin
            blk_open <= 1'b0;        // Engine drains what is left
        end
    end

endmodule

`default_nettype wire

//--- prom_wb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module prom_wb_regs (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               wb_cyc,
    input  wire logic               wb_stb,
    input  wire logic               wb_we,
    input  wire logic [6:0]         wb_adr,
    input  wire logic [31:0]        wb_dat_w,
    input  wire logic               req_ready,
    input  wire logic [31:0]        result,
    input  wire logic [2:0]         eng_state,
    input  wire logic               prom_cs,
    input  wire logic               prom_sclk,
    input  wire logic               prom_mosi,
    input  wire logic               prom_miso,
    input  wire logic               blk_open,
    input  wire logic [15:0]        debug,
    output logic [31:0]             wb_dat_r,
    output logic                    wb_ack,
    output prom_pkg::spi_req_t      req,
    output logic                    req_valid,
    output prom_pkg::blk_wr_t       blk_wr,
    output logic                    blk_start,
    output logic                    blk_end
);

    prom_pkg::prom_cmd_u    cmd_word;
    prom_pkg::spi_req_t     cmd_req;
    prom_pkg::prom_status_t status;
    logic                   cmd_known;   // Opcode maps to a request
    logic                   wb_new;
    logic                   is_cmd;
    logic                   is_start;
    logic                   is_end;
    logic                   in_window;
    logic                   needs_engine;
    logic                   ack_next;

    assign cmd_word     = wb_dat_w;
    assign wb_new       = wb_cyc && wb_stb && !wb_ack;  // Fresh cycle, not yet acked
    assign is_cmd       = (wb_adr == prom_pkg::reg_cmd_status);
    assign is_start     = (wb_adr == prom_pkg::reg_blk_start);
    assign is_end       = (wb_adr == prom_pkg::reg_blk_end);
    assign in_window    = (wb_adr >= prom_pkg::blk_window_base);
    assign needs_engine = wb_we && (is_cmd || is_start);
    assign ack_next     = wb_new && (!needs_engine || (req_ready && !req_valid));  // Back-pressure

    // Bit count lookup by opcode
    always_comb begin
        cmd_req.kind      = prom_pkg::kind_cmd;
        cmd_req.cmd       = cmd_word;
        cmd_req.send_bits = prom_pkg::send_bits_short;
        cmd_req.recv_bits = prom_pkg::recv_bits_none;
        cmd_known         = 1'b1;
        case (cmd_word.spi.opcode)
            prom_pkg::op_wren, prom_pkg::op_wrdi, prom_pkg::op_be, prom_pkg::op_dp: ;
            prom_pkg::op_rdid:      cmd_req.recv_bits = prom_pkg::recv_bits_rdid;
            prom_pkg::op_rdsr:      cmd_req.recv_bits = prom_pkg::recv_bits_rdsr;
            prom_pkg::op_wrsr:      cmd_req.send_bits = prom_pkg::send_bits_wrsr;
            prom_pkg::op_read: begin
                cmd_req.send_bits = prom_pkg::send_bits_read;
                cmd_req.recv_bits = prom_pkg::recv_bits_read;
            end
            prom_pkg::op_fast_read: begin
                cmd_req.send_bits = prom_pkg::send_bits_fast_read;
                cmd_req.recv_bits = prom_pkg::recv_bits_read;
            end
            prom_pkg::op_se:        cmd_req.send_bits = prom_pkg::send_bits_se;
            prom_pkg::op_res: begin
                cmd_req.send_bits = prom_pkg::send_bits_res;
                cmd_req.recv_bits = prom_pkg::recv_bits_res;
            end
            prom_pkg::op_bitio:     cmd_req.kind = prom_pkg::kind_bitio;
            default:                cmd_known = 1'b0;  // 00 and unknown codes
        endcase
    end

    always_comb begin
        status          = '0;
        status.debug    = debug;
        status.busy     = (eng_state != prom_pkg::st_idle) || req_valid;  // Pending counts
        status.cs       = prom_cs;
        status.sclk     = prom_sclk;
        status.miso     = prom_miso;
        status.mosi     = prom_mosi;
        status.blk_open = blk_open;
        status.state    = eng_state;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wb_ack    <= 1'b0;
            req_valid <= 1'b0;
            blk_start <= 1'b0;
            blk_end   <= 1'b0;
            blk_wr    <= '0;
        end else begin
            wb_ack     <= ack_next;                 // Single-cycle ack
            blk_start  <= 1'b0;
            blk_end    <= 1'b0;
            blk_wr.wen <= 1'b0;
            if (req_valid && req_ready)
                req_valid <= 1'b0;                  // Transfer done
            if (ack_next && wb_we) begin
                if ((is_cmd && cmd_known) || is_start)
                    req_valid <= 1'b1;
                blk_start <= is_start;             // Opens buffer with the block request
                blk_end   <= is_end;
                if (in_window) begin
                    blk_wr.wen  <= 1'b1;
                    blk_wr.addr <= wb_adr[5:0];
                    blk_wr.data <= wb_dat_w;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ack_next) begin
            if (wb_we) begin
                if (is_start)
                    req <= '{kind: prom_pkg::kind_block, cmd: '0,
                             send_bits: prom_pkg::send_bits_quadlet,
                             recv_bits: prom_pkg::recv_bits_none};
                else if (is_cmd)
                    req <= cmd_req;
            end else begin
                case (wb_adr)
                    prom_pkg::reg_cmd_status: wb_dat_r <= status;
                    prom_pkg::reg_result:     wb_dat_r <= result;
                    default:                  wb_dat_r <= '0;   // Window reads as zero
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- prom_pkg.sv
`default_nettype none

package prom_pkg;

    // Flash opcodes
    localparam logic [7:0] op_wren      = 8'h06;  // Write enable
    localparam logic [7:0] op_wrdi      = 8'h04;  // Write disable
    localparam logic [7:0] op_rdid      = 8'h9F;  // Read ID, first 3 bytes only
    localparam logic [7:0] op_rdsr      = 8'h05;  // Read status register
    localparam logic [7:0] op_wrsr      = 8'h01;  // Write status register
    localparam logic [7:0] op_read      = 8'h03;  // Read data, 4 bytes
    localparam logic [7:0] op_fast_read = 8'h0B;  // Fast read, dummy byte then 4 bytes
    localparam logic [7:0] op_se        = 8'hD8;  // Sector erase
    localparam logic [7:0] op_be        = 8'hC7;  // Bulk erase
    localparam logic [7:0] op_dp        = 8'hB9;  // Deep power down
    localparam logic [7:0] op_res       = 8'hAB;  // Release, 3 dummy bytes then signature
    localparam logic [7:0] op_bitio     = 8'hFF;  // Direct pin drive

    // Bits shifted out per command
    localparam logic [6:0] send_bits_short     = 7'd8;   // Opcode only
    localparam logic [6:0] send_bits_wrsr      = 7'd16;
    localparam logic [6:0] send_bits_read      = 7'd32;  // Opcode plus 24-bit address
    localparam logic [6:0] send_bits_fast_read = 7'd40;  // Trailing zeros form the dummy byte
    localparam logic [6:0] send_bits_se        = 7'd32;
    localparam logic [6:0] send_bits_res       = 7'd32;
    localparam logic [6:0] send_bits_quadlet   = 7'd32;  // One block quadlet

    // Bits shifted in per command
    localparam logic [6:0] recv_bits_none = 7'd0;
    localparam logic [6:0] recv_bits_rdid = 7'd24;
    localparam logic [6:0] recv_bits_rdsr = 7'd8;
    localparam logic [6:0] recv_bits_read = 7'd32;
    localparam logic [6:0] recv_bits_res  = 7'd8;   // Electronic signature

    // Wishbone word addresses
    localparam logic [6:0] reg_cmd_status  = 7'd0;
    localparam logic [6:0] reg_result      = 7'd1;
    localparam logic [6:0] reg_blk_start   = 7'd2;
    localparam logic [6:0] reg_blk_end     = 7'd3;
    localparam logic [6:0] blk_window_base = 7'd64;  // Upper half is the block window

    // Request kinds
    localparam logic [1:0] kind_cmd   = 2'd0;
    localparam logic [1:0] kind_bitio = 2'd1;
    localparam logic [1:0] kind_block = 2'd2;

    // Engine states
    localparam logic [2:0] st_idle        = 3'd0;
    localparam logic [2:0] st_select      = 3'd1;
    localparam logic [2:0] st_write       = 3'd2;
    localparam logic [2:0] st_write_block = 3'd3;
    localparam logic [2:0] st_read        = 3'd4;
    localparam logic [2:0] st_deselect    = 3'd5;
    localparam logic [2:0] st_settle      = 3'd6;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [23:0] arg;        // Address or status byte, left aligned
    } spi_view_t;

    typedef struct packed {
        logic [23:0] pad;        // Holds the FF opcode
        logic        mask_cs;
        logic        mask_sclk;
        logic        mask_rsvd;
        logic        mask_mosi;
        logic        val_cs;
        logic        val_sclk;
        logic        val_rsvd;
        logic        val_mosi;
    } bitio_view_t;

    typedef union packed {
        spi_view_t   spi;
        bitio_view_t bitio;
    } prom_cmd_u;

    typedef struct packed {
        logic [1:0] kind;
        prom_cmd_u  cmd;
        logic [6:0] send_bits;
        logic [6:0] recv_bits;
    } spi_req_t;

    typedef struct packed {
        logic        wen;
        logic [5:0]  addr;
        logic [31:0] data;
    } blk_wr_t;

    typedef struct packed {
        logic [15:0] debug;      // Last block error, address and expected index
        logic [6:0]  pad;
        logic        busy;
        logic        cs;
        logic        sclk;
        logic        miso;
        logic        mosi;
        logic        blk_open;
        logic [2:0]  state;
    } prom_status_t;

endpackage

`default_nettype wire
